//--- include/lagd_platform.svh
`ifndef LAGD_PLATFORM_SVH
`define LAGD_PLATFORM_SVH

// Elaboration-time check
// Opens a named generate block that only exists when the condition fails
// Use once per scope, without a trailing semicolon
`define STATIC_ASSERT(cond, msg) \
    if (!(cond)) begin : static_assert_fail \
        $error(msg); \
    end

`endif

//--- logic/lagd_mem_pkg.sv
package lagd_mem_pkg;

    // ======================================================================
    // Memory geometry
    // ======================================================================
    localparam int unsigned NumNarrowBanks  = 8;
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 64;
    // Banks covered by one wide port
    localparam int unsigned NarrowPerWide   = WideDataWidth / NarrowDataWidth;
    localparam int unsigned NumWideBanks    = NumNarrowBanks / NarrowPerWide;
    localparam int unsigned BankDepth       = 16;
    // Word address inside a single bank
    localparam int unsigned InBankAddrWidth = $clog2(BankDepth);
    // Cycles from accepted request to read data
    localparam int unsigned RspLatency      = 1;

    typedef logic [NarrowDataWidth-1:0] narrow_data_t;
    typedef logic [WideDataWidth-1:0]   wide_data_t;
    typedef logic [InBankAddrWidth-1:0] bank_addr_t;

    // ======================================================================
    // Narrow port channels
    // ======================================================================
    typedef struct packed {
        bank_addr_t   addr;
        logic         we;
        narrow_data_t wdata;
    } narrow_req_chan_t;

    typedef struct packed {
        logic             q_valid;
        narrow_req_chan_t q;
    } narrow_req_t;

    // Read data channel, valid marks returning data
    typedef struct packed {
        logic         valid;
        narrow_data_t data;
    } narrow_rsp_chan_t;

    typedef struct packed {
        logic             q_ready;
        narrow_rsp_chan_t p;
    } narrow_rsp_t;

    // ======================================================================
    // Wide port channels
    // ======================================================================
    typedef struct packed {
        bank_addr_t addr;
        logic       we;
        wide_data_t wdata;
    } wide_req_chan_t;

    typedef struct packed {
        logic           q_valid;
        wide_req_chan_t q;
    } wide_req_t;

    typedef struct packed {
        logic       valid;
        wide_data_t data;
    } wide_rsp_chan_t;

    typedef struct packed {
        logic           q_ready;
        wide_rsp_chan_t p;
    } wide_rsp_t;

endpackage

//--- logic/wide_to_narrow_splitter.sv
module wide_to_narrow_splitter #(
    parameter type mem_req_t  = lagd_mem_pkg::wide_req_t,
    parameter type mem_rsp_t  = lagd_mem_pkg::wide_rsp_t,
    parameter type bank_req_t = lagd_mem_pkg::narrow_req_t,
    parameter type bank_rsp_t = lagd_mem_pkg::narrow_rsp_t
) (
    input  logic clk_i,
    input  logic rst_ni,

    // Wide side
    input  mem_req_t mem_req_i,
    output mem_rsp_t mem_rsp_o,

    // Bank side, part 0 is the lower bank of the group
    output bank_req_t [lagd_mem_pkg::NarrowPerWide-1:0] bank_req_o,
    input  bank_rsp_t [lagd_mem_pkg::NarrowPerWide-1:0] bank_rsp_i
);

    import lagd_mem_pkg::*;

    // Valid flag of each returning part
    logic [NarrowPerWide-1:0] part_valid;

    // ======================================================================
    // Request split
    // ======================================================================
    // Control fields are shared by all parts
    // Write data is sliced, low slice to part 0
    always_comb begin
        for (int unsigned k = 0; k < NarrowPerWide; k++) begin
            bank_req_o[k]         = '0;
            bank_req_o[k].q_valid = mem_req_i.q_valid;
            bank_req_o[k].q.addr  = mem_req_i.q.addr;
            bank_req_o[k].q.we    = mem_req_i.q.we;
            bank_req_o[k].q.wdata =
                mem_req_i.q.wdata[k*NarrowDataWidth +: NarrowDataWidth];
        end
    end

    // ======================================================================
    // Response merge
    // ======================================================================
    always_comb begin
        for (int unsigned k = 0; k < NarrowPerWide; k++) begin
            part_valid[k] = bank_rsp_i[k].p.valid;
        end
    end

    // Wide data is the concatenation of the parts
    // Ready is owned by the arbiter and left at zero here
    always_comb begin
        mem_rsp_o         = '0;
        // Only valid once every part has returned
        mem_rsp_o.p.valid = &part_valid;
        for (int unsigned k = 0; k < NarrowPerWide; k++) begin
            mem_rsp_o.p.data[k*NarrowDataWidth +: NarrowDataWidth] =
                bank_rsp_i[k].p.data;
        end
    end

    // ======================================================================
    // Assertions
    // ======================================================================
    // All banks of a group are granted together, so the parts
    // of one wide beat come back in the same cycle
    part_valid_agree_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (part_valid == '0) || (&part_valid)
    ) else $error("Wide response parts returned in different cycles");

endmodule

//--- logic/mem_bank.sv
module mem_bank (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Single port, one request per cycle
    input  lagd_mem_pkg::narrow_req_t bank_req_i,
    output lagd_mem_pkg::narrow_rsp_t bank_rsp_o
);

    import lagd_mem_pkg::*;

    // ======================================================================
    // Storage
    // ======================================================================
    narrow_data_t mem_q [BankDepth];

    // Registered read path
    narrow_data_t rdata_q;
    logic         rvalid_q;

    // Decoded access
    logic wr_en;
    logic rd_en;

    assign wr_en = bank_req_i.q_valid && bank_req_i.q.we;
    assign rd_en = bank_req_i.q_valid && !bank_req_i.q.we;

    // Write lands at the accepting edge
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[bank_req_i.q.addr] <= bank_req_i.q.wdata;
        end
    end

    // Read data one cycle after the request
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= mem_q[bank_req_i.q.addr];
        end
    end

    // Every accepted beat answers with a valid, writes included
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bank_req_i.q_valid;
        end
    end

    // Bank never stalls, ready stays low and is not consumed
    always_comb begin
        bank_rsp_o         = '0;
        bank_rsp_o.p.valid = rvalid_q;
        bank_rsp_o.p.data  = rdata_q;
    end

endmodule

//--- logic/wide_narrow_arbiter.sv
`include "lagd_platform.svh"

module wide_narrow_arbiter #(
    parameter type mem_narrow_req_t = lagd_mem_pkg::narrow_req_t,
    parameter type mem_narrow_rsp_t = lagd_mem_pkg::narrow_rsp_t,
    parameter type mem_wide_req_t   = lagd_mem_pkg::wide_req_t,
    parameter type mem_wide_rsp_t   = lagd_mem_pkg::wide_rsp_t
) (
    input  logic clk_i,
    input  logic rst_ni,

    // Narrow ports, port i maps to bank i
    input  mem_narrow_req_t [lagd_mem_pkg::NumNarrowBanks-1:0] mem_narrow_req_i,
    output mem_narrow_rsp_t [lagd_mem_pkg::NumNarrowBanks-1:0] mem_narrow_rsp_o,

    // Wide ports, one per group of adjacent banks
    input  mem_wide_req_t   [lagd_mem_pkg::NumWideBanks-1:0]   mem_wide_req_i,
    output mem_wide_rsp_t   [lagd_mem_pkg::NumWideBanks-1:0]   mem_wide_rsp_o,

    // Bank side
    output mem_narrow_req_t [lagd_mem_pkg::NumNarrowBanks-1:0] mem_bank_req_o,
    input  mem_narrow_rsp_t [lagd_mem_pkg::NumNarrowBanks-1:0] mem_bank_rsp_i
);

    import lagd_mem_pkg::*;

    // Priority bit, 1 gives narrow priority
    logic arb_narrow_q;

    // Split wide traffic per group and part
    mem_narrow_req_t [NumWideBanks-1:0][NarrowPerWide-1:0] wide_split_req;
    mem_narrow_rsp_t [NumWideBanks-1:0][NarrowPerWide-1:0] wide_split_rsp;
    mem_wide_rsp_t   [NumWideBanks-1:0]                    wide_merged_rsp;

    // Per-bank valids and grants
    logic [NumNarrowBanks-1:0] narrow_valid;
    logic [NumNarrowBanks-1:0] wide_valid_split;
    logic [NumNarrowBanks-1:0] narrow_gnt;
    logic [NumNarrowBanks-1:0] wide_gnt;

    // Per-group view
    logic [NumWideBanks-1:0] narrow_valid_grp;
    logic [NumWideBanks-1:0] conflict;
    logic [NumWideBanks-1:0] wide_gnt_grp;

    // Owner tags of beats in flight
    logic [NumNarrowBanks-1:0][RspLatency-1:0] narrow_tag_q;
    logic [NumNarrowBanks-1:0][RspLatency-1:0] wide_tag_q;

    // Round robin between narrow and wide, flips every cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_narrow_q <= 1'b1;
        end else begin
            arb_narrow_q <= ~arb_narrow_q;
        end
    end

    // ======================================================================
    // Wide splitters
    // ======================================================================
    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_split
        wide_to_narrow_splitter #(
            .mem_req_t  (mem_wide_req_t),
            .mem_rsp_t  (mem_wide_rsp_t),
            .bank_req_t (mem_narrow_req_t),
            .bank_rsp_t (mem_narrow_rsp_t)
        ) i_splitter (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .mem_req_i  (mem_wide_req_i[g]),
            .mem_rsp_o  (wide_merged_rsp[g]),
            .bank_req_o (wide_split_req[g]),
            .bank_rsp_i (wide_split_rsp[g])
        );
    end

    // ======================================================================
    // Arbitration
    // ======================================================================
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            narrow_valid[i]     = mem_narrow_req_i[i].q_valid;
            wide_valid_split[i] =
                wide_split_req[i / NarrowPerWide][i % NarrowPerWide].q_valid;
        end
        // A conflict is any narrow valid meeting the wide valid of its group
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            narrow_valid_grp[g] = |narrow_valid[g*NarrowPerWide +: NarrowPerWide];
            conflict[g]         = narrow_valid_grp[g] &&
                                  (|wide_valid_split[g*NarrowPerWide +: NarrowPerWide]);
        end
        // Priority winner takes the whole group
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            narrow_gnt[i] = narrow_valid[i] &&
                            !(conflict[i / NarrowPerWide] && !arb_narrow_q);
            wide_gnt[i]   = wide_valid_split[i] &&
                            (!conflict[i / NarrowPerWide] || !arb_narrow_q);
        end
        // Wide beat only goes when every bank of the group is granted
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            wide_gnt_grp[g] = &wide_gnt[g*NarrowPerWide +: NarrowPerWide];
        end
    end

    // Bank request mux, idle banks see a zero request
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            if (narrow_gnt[i]) begin
                mem_bank_req_o[i] = mem_narrow_req_i[i];
            end else if (wide_gnt[i]) begin
                mem_bank_req_o[i] = wide_split_req[i / NarrowPerWide][i % NarrowPerWide];
            end else begin
                mem_bank_req_o[i] = '0;
            end
        end
    end

    // ======================================================================
    // Response routing
    // ======================================================================
    // Tag shift registers follow each accepted beat through the bank
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            narrow_tag_q <= '0;
            wide_tag_q   <= '0;
        end else begin
            for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
                narrow_tag_q[i][0] <= narrow_gnt[i];
                wide_tag_q[i][0]   <= wide_gnt[i];
                for (int unsigned s = 1; s < RspLatency; s++) begin
                    narrow_tag_q[i][s] <= narrow_tag_q[i][s-1];
                    wide_tag_q[i][s]   <= wide_tag_q[i][s-1];
                end
            end
        end
    end

    // Bank payload goes to its owner only, everyone else sees zero
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            mem_narrow_rsp_o[i]         = '0;
            mem_narrow_rsp_o[i].q_ready = narrow_gnt[i];
            if (narrow_tag_q[i][RspLatency-1]) begin
                mem_narrow_rsp_o[i].p = mem_bank_rsp_i[i].p;
            end
            wide_split_rsp[i / NarrowPerWide][i % NarrowPerWide] = '0;
            if (wide_tag_q[i][RspLatency-1]) begin
                wide_split_rsp[i / NarrowPerWide][i % NarrowPerWide].p = mem_bank_rsp_i[i].p;
            end
        end
    end

    // Merged payload from the splitter, ready from the group grant
    always_comb begin
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            mem_wide_rsp_o[g]         = wide_merged_rsp[g];
            mem_wide_rsp_o[g].q_ready = wide_gnt_grp[g];
        end
    end

    // ======================================================================
    // Assertions
    // ======================================================================
    `STATIC_ASSERT(WideDataWidth % NarrowDataWidth == 0,
        "Wide data width must be a multiple of narrow data width")

    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_bank_chk
        // One owner per bank and cycle
        single_owner_a: assert property (
            @(posedge clk_i) disable iff (!rst_ni)
            !(narrow_gnt[i] && wide_gnt[i])
        ) else $error("Bank %0d granted to narrow and wide at once", i);
    end

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_wide_chk
        wide_ready_valid_a: assert property (
            @(posedge clk_i) disable iff (!rst_ni)
            mem_wide_rsp_o[g].q_ready |-> mem_wide_req_i[g].q_valid
        ) else $error("Wide port %0d ready without valid", g);
    end

endmodule

//--- logic/banked_mem_top.sv
module banked_mem_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Narrow requestors, one per bank
    input  lagd_mem_pkg::narrow_req_t [lagd_mem_pkg::NumNarrowBanks-1:0] narrow_req_i,
    output lagd_mem_pkg::narrow_rsp_t [lagd_mem_pkg::NumNarrowBanks-1:0] narrow_rsp_o,

    // Wide requestors, one per bank group
    input  lagd_mem_pkg::wide_req_t   [lagd_mem_pkg::NumWideBanks-1:0]   wide_req_i,
    output lagd_mem_pkg::wide_rsp_t   [lagd_mem_pkg::NumWideBanks-1:0]   wide_rsp_o
);

    import lagd_mem_pkg::*;

    // Arbiter to bank traffic
    narrow_req_t [NumNarrowBanks-1:0] bank_req;
    narrow_rsp_t [NumNarrowBanks-1:0] bank_rsp;

    // ======================================================================
    // Arbitration
    // ======================================================================
    wide_narrow_arbiter #(
        .mem_narrow_req_t (narrow_req_t),
        .mem_narrow_rsp_t (narrow_rsp_t),
        .mem_wide_req_t   (wide_req_t),
        .mem_wide_rsp_t   (wide_rsp_t)
    ) i_arbiter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_narrow_req_i (narrow_req_i),
        .mem_narrow_rsp_o (narrow_rsp_o),
        .mem_wide_req_i   (wide_req_i),
        .mem_wide_rsp_o   (wide_rsp_o),
        .mem_bank_req_o   (bank_req),
        .mem_bank_rsp_i   (bank_rsp)
    );

    // ======================================================================
    // Banks
    // ======================================================================
    // Bank i sits behind narrow port i
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_bank
        mem_bank i_mem_bank (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .bank_req_i (bank_req[i]),
            .bank_rsp_o (bank_rsp[i])
        );
    end

endmodule

//--- tests/tb_banked_mem.sv
module tb_banked_mem;

    import lagd_mem_pkg::*;

    // Ready bits with narrow ports low and wide ports on top
    typedef logic [NumWideBanks+NumNarrowBanks-1:0] ready_vec_t;

    // One table row whose requests are held until accepted
    typedef struct {
        string                     name;
        logic [NumNarrowBanks-1:0] n_mask;
        logic [NumWideBanks-1:0]   w_mask;
        bank_addr_t                addr;
        logic                      we;
        wide_data_t                wdata;
        int unsigned               cycles_exp;
    } step_t;

    logic clk_i;
    logic rst_ni;

    narrow_req_t [NumNarrowBanks-1:0] narrow_req;
    narrow_rsp_t [NumNarrowBanks-1:0] narrow_rsp;
    wide_req_t   [NumWideBanks-1:0]   wide_req;
    wide_rsp_t   [NumWideBanks-1:0]   wide_rsp;

    // ======================================================================
    // Reference model state
    // ======================================================================
    step_t        steps [$];
    narrow_data_t ref_mem [NumNarrowBanks][BankDepth];
    // Narrow priority when set
    logic         arb_phase;
    narrow_rsp_t  exp_n_rsp [NumNarrowBanks];
    wide_rsp_t    exp_w_rsp [NumWideBanks];
    bit           n_care [NumNarrowBanks];
    bit           w_care [NumWideBanks];
    logic [31:0]  lcg_state = 32'hed38_b9ed;
    int           cycle_cnt = 0;
    int           cycle_limit = 1000;

    banked_mem_top banked_mem_top_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .narrow_req_i (narrow_req),
        .narrow_rsp_o (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_o   (wide_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Phase starts at narrow priority and flips at every edge
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            arb_phase <= 1'b1;
        end else begin
            arb_phase <= ~arb_phase;
        end
    end

    // Hung run guard
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("Run did not finish within %0d cycles", cycle_limit));
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_ready(string name, ready_vec_t exp_rdy, ready_vec_t act_rdy);
        if (act_rdy !== exp_rdy) begin
            fail_run($sformatf("FAIL %s ready: expected %h, actual %h",
                               name, exp_rdy, act_rdy));
        end
    endtask

    task automatic check_narrow_rsp(string name, int port, narrow_rsp_t exp_rsp,
                                    narrow_rsp_t act_rsp, bit data_care);
        // Write responses carry no data
        if (!data_care) begin
            exp_rsp.p.data = act_rsp.p.data;
        end
        if (act_rsp.p !== exp_rsp.p) begin
            fail_run($sformatf("FAIL %s narrow port %0d: expected %h, actual %h",
                               name, port, exp_rsp.p, act_rsp.p));
        end
    endtask

    task automatic check_wide_rsp(string name, int port, wide_rsp_t exp_rsp,
                                  wide_rsp_t act_rsp, bit data_care);
        if (!data_care) begin
            exp_rsp.p.data = act_rsp.p.data;
        end
        if (act_rsp.p !== exp_rsp.p) begin
            fail_run($sformatf("FAIL %s wide port %0d: expected %h, actual %h",
                               name, port, exp_rsp.p, act_rsp.p));
        end
    endtask

    task automatic check_count(string name, int unsigned exp_cnt, int unsigned act_cnt);
        if (act_cnt != exp_cnt) begin
            fail_run($sformatf("FAIL %s cycles: expected %0d, actual %0d",
                               name, exp_cnt, act_cnt));
        end
    endtask

    // ======================================================================
    // Model
    // ======================================================================
    // Conflict when wide and any narrow of the group are valid together
    function automatic ready_vec_t expected_ready(logic [NumNarrowBanks-1:0] nv,
                                                  logic [NumWideBanks-1:0] wv,
                                                  logic narrow_prio);
        ready_vec_t rdy;
        logic       clash;
        rdy = '0;
        for (int g = 0; g < NumWideBanks; g++) begin
            clash = wv[g] && (nv[g*NarrowPerWide +: NarrowPerWide] != '0);
            rdy[NumNarrowBanks+g] = wv[g] && (!clash || !narrow_prio);
            for (int k = 0; k < NarrowPerWide; k++) begin
                rdy[g*NarrowPerWide+k] = nv[g*NarrowPerWide+k] && (!clash || narrow_prio);
            end
        end
        return rdy;
    endfunction

    // Accepted beats answer one cycle later while writes update the model at once
    task automatic record_accepts(step_t s, logic [NumNarrowBanks-1:0] n_acc,
                                  logic [NumWideBanks-1:0] w_acc);
        int lo;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            exp_n_rsp[i] = '0;
            // Idle ports see an all-zero payload
            n_care[i]    = 1'b1;
            if (n_acc[i]) begin
                exp_n_rsp[i].p.valid = 1'b1;
                if (s.we) begin
                    ref_mem[i][s.addr] = s.wdata[NarrowDataWidth-1:0];
                    n_care[i]          = 1'b0;
                end else begin
                    exp_n_rsp[i].p.data = ref_mem[i][s.addr];
                end
            end
        end
        for (int g = 0; g < NumWideBanks; g++) begin
            exp_w_rsp[g] = '0;
            w_care[g]    = 1'b1;
            lo           = g * NarrowPerWide;
            if (w_acc[g]) begin
                exp_w_rsp[g].p.valid = 1'b1;
                w_care[g]            = !s.we;
                // Low slice belongs to the lower bank of the group
                for (int k = 0; k < NarrowPerWide; k++) begin
                    if (s.we) begin
                        ref_mem[lo+k][s.addr] = s.wdata[k*NarrowDataWidth +: NarrowDataWidth];
                    end else begin
                        exp_w_rsp[g].p.data[k*NarrowDataWidth +: NarrowDataWidth] =
                            ref_mem[lo+k][s.addr];
                    end
                end
            end
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic add_step(string name, logic [NumNarrowBanks-1:0] n_mask,
                            logic [NumWideBanks-1:0] w_mask, bank_addr_t addr,
                            logic we, wide_data_t wdata, int unsigned cycles_exp);
        step_t s;
        s.name       = name;
        s.n_mask     = n_mask;
        s.w_mask     = w_mask;
        s.addr       = addr;
        s.we         = we;
        s.wdata      = wdata;
        s.cycles_exp = cycles_exp;
        steps.push_back(s);
    endtask

    task automatic drive_requests(step_t s, logic [NumNarrowBanks-1:0] n_pend,
                                  logic [NumWideBanks-1:0] w_pend);
        for (int i = 0; i < NumNarrowBanks; i++) begin
            narrow_req[i] = '0;
            if (n_pend[i]) begin
                narrow_req[i].q_valid = 1'b1;
                narrow_req[i].q.addr  = s.addr;
                narrow_req[i].q.we    = s.we;
                narrow_req[i].q.wdata = s.wdata[NarrowDataWidth-1:0];
            end
        end
        for (int g = 0; g < NumWideBanks; g++) begin
            wide_req[g] = '0;
            if (w_pend[g]) begin
                wide_req[g].q_valid = 1'b1;
                wide_req[g].q.addr  = s.addr;
                wide_req[g].q.we    = s.we;
                wide_req[g].q.wdata = s.wdata;
            end
        end
    endtask

    // One cycle per pass where losers keep valid and retry
    task automatic run_step(step_t s);
        logic [NumNarrowBanks-1:0] n_pend;
        logic [NumWideBanks-1:0]   w_pend;
        ready_vec_t                rdy_exp;
        ready_vec_t                rdy_act;
        int unsigned               cycles;
        n_pend = s.n_mask;
        w_pend = s.w_mask;
        cycles = 0;
        do begin
            @(negedge clk_i);
            drive_requests(s, n_pend, w_pend);
            #1;
            rdy_exp = expected_ready(n_pend, w_pend, arb_phase);
            for (int i = 0; i < NumNarrowBanks; i++) begin
                rdy_act[i] = narrow_rsp[i].q_ready;
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                rdy_act[NumNarrowBanks+g] = wide_rsp[g].q_ready;
            end
            check_ready(s.name, rdy_exp, rdy_act);
            for (int i = 0; i < NumNarrowBanks; i++) begin
                check_narrow_rsp(s.name, i, exp_n_rsp[i], narrow_rsp[i], n_care[i]);
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                check_wide_rsp(s.name, g, exp_w_rsp[g], wide_rsp[g], w_care[g]);
            end
            record_accepts(s, rdy_exp[NumNarrowBanks-1:0],
                           rdy_exp[NumNarrowBanks +: NumWideBanks]);
            n_pend &= ~rdy_exp[NumNarrowBanks-1:0];
            w_pend &= ~rdy_exp[NumNarrowBanks +: NumWideBanks];
            cycles++;
        end while ((n_pend != '0) || (w_pend != '0));
        check_count(s.name, s.cycles_exp, cycles);
    endtask

    initial begin
        rst_ni     = 1'b0;
        narrow_req = '0;
        wide_req   = '0;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            exp_n_rsp[i] = '0;
            n_care[i]    = 1'b1;
        end
        for (int g = 0; g < NumWideBanks; g++) begin
            exp_w_rsp[g] = '0;
            w_care[g]    = 1'b1;
        end

        // name, narrow mask, wide mask, addr, we, wdata, cycles
        add_step("idle_after_reset", 8'h00, 4'h0, 4'h0, 1'b0, '0, 1);
        add_step("narrow_wr_p3", 8'h08, 4'h0, 4'h2, 1'b1, {32'h0, lcg_next()}, 1);
        add_step("narrow_rd_p3", 8'h08, 4'h0, 4'h2, 1'b0, '0, 1);
        add_step("wide_wr_p1", 8'h00, 4'h2, 4'h7, 1'b1, {lcg_next(), lcg_next()}, 1);
        add_step("wide_rd_p1", 8'h00, 4'h2, 4'h7, 1'b0, '0, 1);
        add_step("narrow_rd_b2_b3", 8'h0c, 4'h0, 4'h7, 1'b0, '0, 1);
        // Group 0 conflict where the odd idle step swaps the starting winner
        add_step("conflict_g0", 8'h02, 4'h1, 4'h5, 1'b1, {lcg_next(), lcg_next()}, 2);
        add_step("idle_gap", 8'h00, 4'h0, 4'h0, 1'b0, '0, 1);
        add_step("conflict_g0_swap", 8'h02, 4'h1, 4'h5, 1'b1, {lcg_next(), lcg_next()}, 2);
        add_step("wide_rd_g0", 8'h00, 4'h1, 4'h5, 1'b0, '0, 1);
        // Different groups never block each other
        add_step("cross_group_wr", 8'h01, 4'h4, 4'h9, 1'b1, {lcg_next(), lcg_next()}, 1);
        add_step("cross_group_rd", 8'h01, 4'h4, 4'h9, 1'b0, '0, 1);
        add_step("cross_group_rd_odd", 8'h01, 4'h4, 4'h9, 1'b0, '0, 1);
        for (int unsigned a = 1; a <= 3; a++) begin
            add_step($sformatf("b2b_wr_a%0d", a), 8'h20, 4'h0, bank_addr_t'(a), 1'b1,
                     {32'h0, lcg_next()}, 1);
        end
        // Several reads in flight on port 5
        for (int unsigned a = 1; a <= 3; a++) begin
            add_step($sformatf("b2b_rd_a%0d", a), 8'h20, 4'h0, bank_addr_t'(a), 1'b0, '0, 1);
        end
        add_step("drain", 8'h00, 4'h0, 4'h0, 1'b0, '0, 1);

        cycle_limit = 4 * steps.size() + 5;

        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (steps[n]) begin
            run_step(steps[n]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
logic/lagd_mem_pkg.sv
logic/wide_to_narrow_splitter.sv
logic/mem_bank.sv
logic/wide_narrow_arbiter.sv
logic/banked_mem_top.sv
tests/tb_banked_mem.sv

//--- run.sh
#!/bin/sh
# Build and run the banked scratchpad testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_banked_mem
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

exit 0
